// ==== verilog/uart_frame_pkg.sv ====
package uart_frame_pkg;

   // One character on the line
   typedef logic [7:0] data_t;

   // Counts 16x ticks and holds up to 32 for 2 stop bits
   typedef logic [5:0] tick_cnt_t;

   // Index of the data bit in flight
   typedef logic [2:0] bit_cnt_t;

   // Ticks per bit period
   localparam int OVERSAMPLE = 16;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

endpackage

// ==== verilog/uart_reg_pkg.sv ====
package uart_reg_pkg;

   // Register select on the host bus
   typedef logic [1:0] addr_t;

   // Baud divisor giving a tick every div+1 clocks
   typedef logic [15:0] div_t;

   // Register map
   localparam addr_t ADDR_DATA   = 2'd0;
   localparam addr_t ADDR_STATUS = 2'd1;
   localparam addr_t ADDR_DIV_LO = 2'd2;
   localparam addr_t ADDR_DIV_HI = 2'd3;

   // Bit positions in the status byte
   localparam int STAT_RX_VALID = 0;
   localparam int STAT_TX_BUSY  = 1;
   localparam int STAT_OVERRUN  = 2;

endpackage

// ==== verilog/uart_baud_gen.sv ====
module uart_baud_gen
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  uart_reg_pkg::div_t i_div,
   input  logic               i_div_load,
   output logic               o_tick
);

   import uart_reg_pkg::*;

   div_t cnt;

   // Down-counter ticks each time it passes zero
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         cnt    <= '0;
         o_tick <= 1'b0;
      end
      else if (i_div_load)
      begin
         // New rate starts a fresh period
         cnt    <= i_div;
         o_tick <= 1'b0;
      end
      else if (cnt == '0)
      begin
         cnt    <= i_div;
         o_tick <= 1'b1;
      end
      else
      begin
         cnt    <= cnt - 1'b1;
         o_tick <= 1'b0;
      end
   end

endmodule

// ==== verilog/uart_rx.sv ====
module uart_rx
#(
   parameter int SB_TICK = 16
)
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_bit,
   input  logic                  i_tick,
   output logic                  o_done_data,
   output uart_frame_pkg::data_t o_data
);

   import uart_frame_pkg::*;

   // Half a bit after the falling edge is mid-start
   localparam int HALF_BIT = OVERSAMPLE / 2;

   rx_state_e state_reg;
   rx_state_e state_next;
   tick_cnt_t s_reg;
   tick_cnt_t s_next;
   bit_cnt_t  n_reg;
   bit_cnt_t  n_next;
   data_t     b_reg;
   data_t     b_next;

   ////////////////////////////////////////
   // State and counters
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         state_reg <= RX_IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end
   end

   // Shift register
   always_ff @(posedge i_clk)
   begin
      b_reg <= b_next;
   end

   ////////////////////////////////////////
   // Next state and data path
   always_comb
   begin
      state_next  = state_reg;
      s_next      = s_reg;
      n_next      = n_reg;
      b_next      = b_reg;
      o_done_data = 1'b0;

      case (state_reg)
         RX_IDLE:
         begin
            // Low line means a start bit has begun
            if (!i_bit)
            begin
               state_next = RX_START;
               s_next     = '0;
            end
         end
         RX_START:
         begin
            if (i_tick)
            begin
               if (s_reg == tick_cnt_t'(HALF_BIT - 1))
               begin
                  state_next = RX_DATA;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         RX_DATA:
         begin
            if (i_tick)
            begin
               if (s_reg == tick_cnt_t'(OVERSAMPLE - 1))
               begin
                  // Mid-bit sample with the LSB arriving first
                  s_next = '0;
                  b_next = {i_bit, b_reg[7:1]};
                  if (n_reg == bit_cnt_t'(7))
                     state_next = RX_STOP;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         RX_STOP:
         begin
            if (i_tick)
            begin
               if (s_reg == tick_cnt_t'(SB_TICK - 1))
               begin
                  state_next  = RX_IDLE;
                  o_done_data = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         default:
            state_next = RX_IDLE;
      endcase
   end

   assign o_data = b_reg;

endmodule

// ==== verilog/uart_tx.sv ====
module uart_tx
#(
   parameter int SB_TICK = 16
)
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_tick,
   input  logic                  i_start,
   input  uart_frame_pkg::data_t i_data,
   output logic                  o_busy,
   output logic                  o_bit
);

   import uart_frame_pkg::*;

   tx_state_e state_reg;
   tx_state_e state_next;
   tick_cnt_t s_reg;
   tick_cnt_t s_next;
   bit_cnt_t  n_reg;
   bit_cnt_t  n_next;
   data_t     b_reg;
   data_t     b_next;
   logic      tx_reg;
   logic      tx_next;

   ////////////////////////////////////////
   // State, counters and line register
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         state_reg <= TX_IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end
   end

   always_ff @(posedge i_clk)
   begin
      b_reg <= b_next;
   end

   ////////////////////////////////////////
   // Next state and line level
   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      tx_next    = 1'b1;

      case (state_reg)
         TX_IDLE:
         begin
            // A start while busy never reaches here
            if (i_start)
            begin
               state_next = TX_START;
               s_next     = '0;
               b_next     = i_data;
            end
         end
         TX_START:
         begin
            tx_next = 1'b0;
            if (i_tick)
            begin
               if (s_reg == tick_cnt_t'(OVERSAMPLE - 1))
               begin
                  state_next = TX_DATA;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         TX_DATA:
         begin
            tx_next = b_reg[0];
            if (i_tick)
            begin
               if (s_reg == tick_cnt_t'(OVERSAMPLE - 1))
               begin
                  s_next = '0;
                  b_next = b_reg >> 1;
                  if (n_reg == bit_cnt_t'(7))
                     state_next = TX_STOP;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         TX_STOP:
         begin
            if (i_tick)
            begin
               if (s_reg == tick_cnt_t'(SB_TICK - 1))
                  state_next = TX_IDLE;
               else
                  s_next = s_reg + 1'b1;
            end
         end
         default:
            state_next = TX_IDLE;
      endcase
   end

   assign o_busy = (state_reg != TX_IDLE);
   assign o_bit  = tx_reg;

endmodule

// ==== verilog/uart_regs.sv ====
module uart_regs
#(
   parameter uart_reg_pkg::div_t RST_DIV = 16'd1
)
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_wr,
   input  logic                  i_rd,
   input  uart_reg_pkg::addr_t   i_addr,
   input  uart_frame_pkg::data_t i_wdata,
   output uart_frame_pkg::data_t o_rdata,
   output logic                  o_irq,
   output uart_reg_pkg::div_t    o_div,
   output logic                  o_div_load,
   output uart_frame_pkg::data_t o_tx_data,
   output logic                  o_tx_start,
   input  logic                  i_tx_busy,
   input  uart_frame_pkg::data_t i_rx_data,
   input  logic                  i_rx_done
);

   import uart_frame_pkg::*;
   import uart_reg_pkg::*;

   data_t div_lo;
   data_t div_hi;
   data_t rx_byte;
   data_t status;
   logic  rx_valid;
   logic  overrun;
   logic  wr_data;
   logic  rd_data;
   logic  rd_status;

   assign wr_data   = i_wr && (i_addr == ADDR_DATA);
   assign rd_data   = i_rd && (i_addr == ADDR_DATA);
   assign rd_status = i_rd && (i_addr == ADDR_STATUS);

   ////////////////////////////////////////
   // Control registers and flags
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
      begin
         div_lo     <= RST_DIV[7:0];
         div_hi     <= RST_DIV[15:8];
         o_div_load <= 1'b0;
         o_tx_start <= 1'b0;
         rx_valid   <= 1'b0;
         overrun    <= 1'b0;
      end
      else
      begin
         o_tx_start <= wr_data;
         o_div_load <= i_wr && (i_addr == ADDR_DIV_LO || i_addr == ADDR_DIV_HI);
         if (i_wr && i_addr == ADDR_DIV_LO)
            div_lo <= i_wdata;
         if (i_wr && i_addr == ADDR_DIV_HI)
            div_hi <= i_wdata;

         // A new byte wins over a clearing read
         if (i_rx_done)
            rx_valid <= 1'b1;
         else if (rd_data)
            rx_valid <= 1'b0;

         if (i_rx_done && rx_valid)
            overrun <= 1'b1;
         else if (rd_status)
            overrun <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Data path and read mux
   always_comb
   begin
      status = '0;
      status[STAT_RX_VALID] = rx_valid;
      // Queued start counts as busy
      status[STAT_TX_BUSY]  = i_tx_busy | o_tx_start;
      status[STAT_OVERRUN]  = overrun;
   end

   always_ff @(posedge i_clk)
   begin
      if (wr_data)
         o_tx_data <= i_wdata;
      if (i_rx_done)
         rx_byte <= i_rx_data;
      if (i_rd)
      begin
         case (i_addr)
            ADDR_DATA:   o_rdata <= rx_byte;
            ADDR_STATUS: o_rdata <= status;
            ADDR_DIV_LO: o_rdata <= div_lo;
            default:     o_rdata <= div_hi;
         endcase
      end
   end

   assign o_div = {div_hi, div_lo};
   assign o_irq = rx_valid;

endmodule

// ==== verilog/uart_top.sv ====
module uart_top
#(
   parameter int                 SB_TICK = 16,
   parameter uart_reg_pkg::div_t RST_DIV = 16'd1
)
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_wr,
   input  logic                  i_rd,
   input  uart_reg_pkg::addr_t   i_addr,
   input  uart_frame_pkg::data_t i_wdata,
   output uart_frame_pkg::data_t o_rdata,
   output logic                  o_irq,
   input  logic                  i_rxd,
   output logic                  o_txd
);

   import uart_frame_pkg::*;
   import uart_reg_pkg::*;

   div_t  div;
   logic  div_load;
   logic  tick;
   data_t tx_data;
   logic  tx_start;
   logic  tx_busy;
   data_t rx_data;
   logic  rx_done;

   uart_regs #(
      .RST_DIV (RST_DIV)
   ) u_regs (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_wr       (i_wr),
      .i_rd       (i_rd),
      .i_addr     (i_addr),
      .i_wdata    (i_wdata),
      .o_rdata    (o_rdata),
      .o_irq      (o_irq),
      .o_div      (div),
      .o_div_load (div_load),
      .o_tx_data  (tx_data),
      .o_tx_start (tx_start),
      .i_tx_busy  (tx_busy),
      .i_rx_data  (rx_data),
      .i_rx_done  (rx_done)
   );

   uart_baud_gen u_baud_gen (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_div      (div),
      .i_div_load (div_load),
      .o_tick     (tick)
   );

   uart_rx #(
      .SB_TICK (SB_TICK)
   ) u_rx (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_bit       (i_rxd),
      .i_tick      (tick),
      .o_done_data (rx_done),
      .o_data      (rx_data)
   );

   uart_tx #(
      .SB_TICK (SB_TICK)
   ) u_tx (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_tick  (tick),
      .i_start (tx_start),
      .i_data  (tx_data),
      .o_busy  (tx_busy),
      .o_bit   (o_txd)
   );

endmodule

// ==== tests/tb_uart_top.sv ====
module tb_uart_top;

   timeunit 1ns;
   timeprecision 100ps;

   import uart_frame_pkg::*;
   import uart_reg_pkg::*;

   localparam div_t TB_RST_DIV = 16'd1;
   localparam int   NUM_FRAMES = 20;
   localparam int   MAX_DIV    = 5;
   // Frames x bits x ticks x clocks per tick x period x 2 for margin
   localparam longint WATCHDOG_NS = NUM_FRAMES * 10 * 16 * (MAX_DIV + 1) * 10 * 2;

   logic        clk;
   logic        rst;
   logic        wr;
   logic        rd;
   addr_t       addr;
   data_t       wdata;
   data_t       rdata;
   logic        irq;
   wire         txd;
   int          mismatches = 0;
   int          other_errs = 0;
   div_t        cur_div    = TB_RST_DIV;
   logic [31:0] lcg_state  = 32'h61d4_f7ab;

   // Serial loopback with TX feeding RX
   uart_top #(
      .SB_TICK (16),
      .RST_DIV (TB_RST_DIV)
   ) DUT (
      .i_clk   (clk),
      .i_rst   (rst),
      .i_wr    (wr),
      .i_rd    (rd),
      .i_addr  (addr),
      .i_wdata (wdata),
      .o_rdata (rdata),
      .o_irq   (irq),
      .i_rxd   (txd),
      .o_txd   (txd)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Compare tasks and random source
   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act)
      begin
         mismatches++;
         $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_div(input string name, input div_t exp, input div_t act);
      if (exp !== act)
      begin
         mismatches++;
         $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         mismatches++;
         $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   ////////////////////////////////////////
   // Bus access and waiting
   task automatic bus_write(input addr_t a, input data_t d);
      @(negedge clk);
      wr    = 1'b1;
      addr  = a;
      wdata = d;
      @(negedge clk);
      wr = 1'b0;
   endtask

   // Read data is registered, so it is sampled one cycle later
   task automatic bus_read(input addr_t a, output data_t d);
      @(negedge clk);
      rd   = 1'b1;
      addr = a;
      @(negedge clk);
      rd = 1'b0;
      d  = rdata;
   endtask

   task automatic set_div(input div_t d);
      bus_write(ADDR_DIV_LO, d[7:0]);
      bus_write(ADDR_DIV_HI, d[15:8]);
      cur_div = d;
   endtask

   task automatic wait_irq(input string what);
      int bound;
      int cnt;
      bound = 320 * (int'(cur_div) + 1) + 200;
      cnt   = 0;
      while (!irq && cnt < bound)
      begin
         @(negedge clk);
         cnt++;
      end
      if (!irq)
      begin
         other_errs++;
         $display("error at %0t: no byte arrived within %0d cycles (%s)", $time, bound, what);
      end
   endtask

   // Polls status until one bit reaches the wanted level
   task automatic poll_status(input int pos, input logic want, output data_t st);
      int bound;
      int cnt;
      bound = 200 * (int'(cur_div) + 1) + 100;
      cnt   = 0;
      bus_read(ADDR_STATUS, st);
      while (st[pos] !== want && cnt < bound)
      begin
         bus_read(ADDR_STATUS, st);
         cnt++;
      end
      if (st[pos] !== want)
      begin
         other_errs++;
         $display("error at %0t: status bit %0d never became %b", $time, pos, want);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   task automatic test_reset();
      data_t st;
      data_t lo;
      data_t hi;
      check_bit("o_txd", 1'b1, txd);
      check_bit("o_irq", 1'b0, irq);
      bus_read(ADDR_STATUS, st);
      check_data("status", 8'h00, st);
      bus_read(ADDR_DIV_LO, lo);
      bus_read(ADDR_DIV_HI, hi);
      check_div("divisor", TB_RST_DIV, {hi, lo});
   endtask

   task automatic test_div_regs();
      data_t lo;
      data_t hi;
      set_div(16'hc35a);
      bus_read(ADDR_DIV_LO, lo);
      bus_read(ADDR_DIV_HI, hi);
      check_div("divisor", 16'hc35a, {hi, lo});
      set_div(16'd3);
      bus_read(ADDR_DIV_LO, lo);
      bus_read(ADDR_DIV_HI, hi);
      check_div("divisor", 16'd3, {hi, lo});
   endtask

   task automatic send_and_check(input data_t b);
      data_t st;
      data_t got;
      bus_write(ADDR_DATA, b);
      wait_irq("loopback");
      bus_read(ADDR_STATUS, st);
      check_bit("status.rx_valid", 1'b1, st[STAT_RX_VALID]);
      check_bit("status.overrun", 1'b0, st[STAT_OVERRUN]);
      bus_read(ADDR_DATA, got);
      check_data("rx data", b, got);
      check_bit("o_irq", 1'b0, irq);
      poll_status(STAT_TX_BUSY, 1'b0, st);
   endtask

   task automatic test_busy();
      data_t st;
      data_t got;
      bus_write(ADDR_DATA, 8'ha5);
      bus_read(ADDR_STATUS, st);
      check_bit("status.tx_busy", 1'b1, st[STAT_TX_BUSY]);
      // Dropped by the busy transmitter
      bus_write(ADDR_DATA, 8'h3c);
      wait_irq("busy test");
      bus_read(ADDR_DATA, got);
      check_data("rx data", 8'ha5, got);
      poll_status(STAT_TX_BUSY, 1'b0, st);
      bus_read(ADDR_STATUS, st);
      check_bit("status.tx_busy", 1'b0, st[STAT_TX_BUSY]);
      check_bit("status.rx_valid", 1'b0, st[STAT_RX_VALID]);
   endtask

   task automatic test_overrun();
      data_t st;
      data_t got;
      bus_write(ADDR_DATA, 8'h81);
      poll_status(STAT_TX_BUSY, 1'b0, st);
      bus_write(ADDR_DATA, 8'h7e);
      // First status showing overrun also clears it
      poll_status(STAT_OVERRUN, 1'b1, st);
      check_bit("status.rx_valid", 1'b1, st[STAT_RX_VALID]);
      bus_read(ADDR_DATA, got);
      check_data("rx data", 8'h7e, got);
      bus_read(ADDR_STATUS, st);
      check_bit("status.overrun", 1'b0, st[STAT_OVERRUN]);
      poll_status(STAT_TX_BUSY, 1'b0, st);
   endtask

   task automatic test_random();
      div_t divs [2];
      divs[0] = 16'd0;
      divs[1] = 16'd5;
      foreach (divs[i])
      begin
         set_div(divs[i]);
         repeat (8)
            send_and_check(data_t'(lcg_next() >> 24));
      end
   endtask

   ////////////////////////////////////////
   initial
   begin
      rst   = 1'b1;
      wr    = 1'b0;
      rd    = 1'b0;
      addr  = '0;
      wdata = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_reset();
      test_div_regs();
      send_and_check(8'h5d);
      test_busy();
      test_overrun();
      test_random();

      $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // Watchdog against a stuck run
   initial
   begin
      #(WATCHDOG_NS);
      $display("error: watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
      $display("test failed");
      $finish;
   end

endmodule

// ==== build.f ====
verilog/uart_frame_pkg.sv
verilog/uart_reg_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
tests/tb_uart_top.sv

// ==== Bender.yml ====
package:
  name: uart_top

sources:
  - verilog/uart_frame_pkg.sv
  - verilog/uart_reg_pkg.sv
  - verilog/uart_baud_gen.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/uart_regs.sv
  - verilog/uart_top.sv
  - target: test
    files:
      - tests/tb_uart_top.sv
